// File: Bender.yml
package:
  name: reg_file

dependencies: {}

sources:
  # register file RTL, package first
  - files:
      - hdl/reg_file_pkg.sv
      - hdl/reg_storage.sv
      - hdl/reg_read_port.sv
      - hdl/reg_file.sv

  # testbench with clock generator and bound assertions
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/reg_file_assertions.sv
      - sim/tb_reg_file.sv

// File: filelist.f
hdl/reg_file_pkg.sv
hdl/reg_storage.sv
hdl/reg_read_port.sv
hdl/reg_file.sv
sim/tb_clock_gen.sv
sim/reg_file_assertions.sv
sim/tb_reg_file.sv

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
	// two ports by default, one for rs and one for rt
	parameter int NUM_READ_PORTS = 2
) (
	input  logic                     clock,
	input  logic                     reset,
	input  reg_file_pkg::reg_write_t write,
	input  reg_file_pkg::reg_id_t    read_id    [NUM_READ_PORTS],
	output reg_file_pkg::word_t      read_value [NUM_READ_PORTS]
);

	import reg_file_pkg::*;

	// current register contents, shared by all read ports
	reg_array_t regs;

	// the single storage block holds the thirty-two registers
	// it takes the write request at the rising edge and keeps $zero at zero
	reg_storage u_storage (
		.clock (clock),
		.reset (reset),
		.write (write),
		.regs  (regs)
	);

	// every read port is the same combinational mux with a write bypass
	// each one sees the full register array and the same write request,
	// so any port can forward the value that is being written this cycle
	// ports are independent of each other, and two ports reading the same
	// register simply return the same word
	for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_read_port
		reg_read_port u_read_port (
			.write      (write),
			.regs       (regs),
			.read_id    (read_id[p]),
			.read_value (read_value[p])
		);
	end

	// there is no handshake and no status output
	// a write is accepted every cycle that write.en is high, and a read is
	// answered in the same cycle that its id is presented
	// port 0 is normally wired to the rs field and port 1 to rt, but the file
	// itself does not care which operand a port serves

endmodule

// File: hdl/reg_file_pkg.sv
package reg_file_pkg;

	// the core has thirty-two general registers, as the MIPS ISA defines them
	localparam int REG_COUNT = 32;

	// an id must be wide enough to name every register
	localparam int REG_ID_WIDTH = $clog2(REG_COUNT);

	// all general registers hold one full machine word
	localparam int WORD_WIDTH = 32;

	// register id as it comes out of the rs, rt or rd field of an instruction
	typedef logic [REG_ID_WIDTH-1:0] reg_id_t;

	// one register value
	typedef logic [WORD_WIDTH-1:0] word_t;

	// a single write request from the writeback stage
	// en is a plain level and is sampled at every rising clock edge
	// id names the destination, and id 0 is accepted but never stored
	// data is the value to store, and it is also what the read ports forward
	typedef struct packed {
		logic    en;
		reg_id_t id;
		word_t   data;
	} reg_write_t;

	// the whole register contents, register 0 in the lowest word
	// storage drives this to every read port so that each port can pick
	// its own register without a separate bus per port
	typedef word_t [REG_COUNT-1:0] reg_array_t;

	// the zero register always reads as this value
	localparam word_t ZERO_WORD = '0;

	// id of the hardwired zero register
	localparam reg_id_t ZERO_ID = '0;

endpackage

// File: hdl/reg_read_port.sv
`timescale 1ns/1ps

module reg_read_port (
	input  reg_file_pkg::reg_write_t write,
	input  reg_file_pkg::reg_array_t regs,
	input  reg_file_pkg::reg_id_t    read_id,
	output reg_file_pkg::word_t      read_value
);

	import reg_file_pkg::*;

	// the value held in storage for the addressed register
	word_t stored_value;

	// high when the write in flight targets the register this port reads
	logic forward_hit;

	// pick the addressed word out of the register array
	// this is a plain mux on read_id, so the port has no clock and no latency
	always_comb begin
		stored_value = regs[read_id];
	end

	// a write presented in this cycle only lands in storage at the next
	// rising edge, so a read of the same register would still see the old
	// value without the bypass below
	// id 0 is excluded, because a write to $zero is dropped by storage and
	// must not become visible through the bypass either
	always_comb begin
		forward_hit = write.en && (write.id == read_id) && (write.id != ZERO_ID);
	end

	// the forwarded data replaces the stored word on a hit
	// a read of register 0 never hits, and storage already keeps that word at
	// zero, so there is no need to mask it a second time here
	always_comb begin
		if (forward_hit) begin
			read_value = write.data;
		end else begin
			read_value = stored_value;
		end
	end

	// read_value follows read_id, regs and the write request within the same
	// cycle, so a consumer can sample it at the next rising edge as usual
	// the net effect matches the falling-edge write of the older design
	// without needing a second clock edge inside the core

endmodule

// File: hdl/reg_storage.sv
`timescale 1ns/1ps

module reg_storage (
	input  logic                     clock,
	input  logic                     reset,
	input  reg_file_pkg::reg_write_t write,
	output reg_file_pkg::reg_array_t regs
);

	import reg_file_pkg::*;

	// one enable bit per register, at most one of them set
	logic [REG_COUNT-1:0] write_onehot;

	// registers 1 to 31 are real flops; register 0 has no storage at all
	word_t regs_q [REG_COUNT-1:1];

	// turn the destination id into a one-hot enable
	// the enable is qualified by write.en so that an idle cycle sets no bit
	always_comb begin
		write_onehot = '0;
		write_onehot[write.id] = write.en;
		// register 0 is $zero and software relies on it staying zero, so
		// its enable is masked here and a write to it simply has no effect
		write_onehot[0] = 1'b0;
	end

	// the writable registers update on the rising edge
	// the reference design wrote on the falling edge so that a read in the
	// same cycle saw the new value, while here the read ports forward the
	// pending write instead and the whole block stays on a single edge
	always_ff @(posedge clock) begin
		if (reset) begin
			// reset clears every register so that software starts from zero
			for (int i = 1; i < REG_COUNT; i++) begin
				regs_q[i] <= ZERO_WORD;
			end
		end else begin
			for (int i = 1; i < REG_COUNT; i++) begin
				// each register only looks at its own enable bit
				if (write_onehot[i]) begin
					regs_q[i] <= write.data;
				end
			end
		end
	end

	// gather the flops into the packed array that feeds the read ports
	always_comb begin
		// register 0 is driven as a constant zero rather than kept in a flop,
		// so it reads as zero even before the first reset and no stray write
		// path can ever reach it
		regs[0] = ZERO_WORD;
		for (int i = 1; i < REG_COUNT; i++) begin
			regs[i] = regs_q[i];
		end
	end

	// note that regs shows a write one cycle after it was presented, which is
	// why the read ports have to forward the write that is still pending
	// a write that comes with reset high is dropped, since reset wins above

endmodule

// File: sim/reg_file_assertions.sv
`timescale 1ns/1ps

module reg_file_assertions #(
	parameter int NUM_READ_PORTS = 2
) (
	input logic                     clock,
	input logic                     reset,
	input reg_file_pkg::reg_write_t write,
	input reg_file_pkg::reg_id_t    read_id    [NUM_READ_PORTS],
	input reg_file_pkg::word_t      read_value [NUM_READ_PORTS]
);

	import reg_file_pkg::*;

	// storage holds unknown values until the first reset edge
	logic reset_seen = 1'b0;

	// the write that storage took at the last edge, if it really stored one
	logic       last_valid = 1'b0;
	reg_write_t last_write;

	// number of failed assertions so far, which the testbench watches
	int failures = 0;

	always @(posedge clock) begin
		if (reset) begin
			reset_seen <= 1'b1;
		end
		// a write under reset or to $zero never reaches storage
		last_valid <= write.en && (write.id != ZERO_ID) && !reset;
		last_write <= write;
	end

	for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_port_checks

		// $zero reads as zero on every port, whatever is being written
		zero_reads_zero: assert property (@(posedge clock)
			(read_id[p] == ZERO_ID) |-> (read_value[p] == ZERO_WORD))
			else begin
				$error("port %0d returned a nonzero value for register 0", p);
				failures++;
			end

		// once reset has cleared storage every output is a known value
		no_unknown_output: assert property (@(posedge clock)
			disable iff (reset || !reset_seen) !$isunknown(read_value[p]))
			else begin
				$error("port %0d drives an unknown value", p);
				failures++;
			end

		// a stored write is seen from regs in the next cycle unless a newer
		// write to the same register is being forwarded over it
		write_then_read: assert property (@(posedge clock) disable iff (reset)
			(last_valid && (read_id[p] == last_write.id)
				&& !(write.en && (write.id == last_write.id)))
			|-> (read_value[p] == last_write.data))
			else begin
				$error("port %0d lost the write to register %0d", p, last_write.id);
				failures++;
			end
	end

endmodule

bind reg_file reg_file_assertions #(
	.NUM_READ_PORTS (NUM_READ_PORTS)
) u_assertions (
	.clock      (clock),
	.reset      (reset),
	.write      (write),
	.read_id    (read_id),
	.read_value (read_value)
);

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	// full clock period in ns
	parameter int PERIOD_NS = 8,
	// number of rising edges that see reset high
	parameter int RESET_CYCLES = 2
) (
	output logic clock,
	output logic reset
);

	// free-running clock, first rising edge after half a period
	initial begin
		clock = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clock = ~clock;
		end
	end

	// reset drops just after the last reset edge, like any other driven input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#1 reset = 1'b0;
	end

endmodule

// File: sim/tb_reg_file.sv
`timescale 1ns/1ps

module tb_reg_file;

	import reg_file_pkg::*;

	localparam int NUM_READ_PORTS = 2;
	localparam int PERIOD_NS = 8;
	// inputs change this long after a rising edge
	localparam int DRIVE_DELAY = 1;
	// outputs are compared 1 ns before the next rising edge
	localparam int CHECK_DELAY = PERIOD_NS - 1;
	localparam int RANDOM_CYCLES = 500;
	// the second reset is held for two cycles from this random step
	localparam int MID_RESET_AT = 250;
	// directed phases need about 200 cycles and the random phase 500,
	// so this limit leaves close to three times the expected run length
	localparam int MAX_CYCLES = 2000;
	localparam logic [31:0] LFSR_SEED = 32'he62a6f32;

	logic       clock;
	logic       power_on_reset;
	logic       reset_request;
	logic       reset;
	reg_write_t write;
	reg_id_t    read_id    [NUM_READ_PORTS];
	word_t      read_value [NUM_READ_PORTS];

	// reference model state, register 0 is never written so it stays zero
	reg_array_t  shadow;
	logic        model_valid;
	logic [31:0] lfsr_state;
	int          cycle_count;

	tb_clock_gen #(
		.PERIOD_NS    (PERIOD_NS),
		.RESET_CYCLES (2)
	) u_clock_gen (
		.clock (clock),
		.reset (power_on_reset)
	);

	// the stimulus can add a reset of its own in the middle of the run
	assign reset = power_on_reset | reset_request;

	reg_file #(
		.NUM_READ_PORTS (NUM_READ_PORTS)
	) dut (
		.clock      (clock),
		.reset      (reset),
		.write      (write),
		.read_id    (read_id),
		.read_value (read_value)
	);

	// one step of a 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// collects count fresh bits, one LFSR step for every bit
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// a value that differs for every register id
	function automatic word_t fill_value(input reg_id_t id);
		return (32'h0101_0101 * id) ^ 32'hc3a5_5a3c;
	endfunction

	function automatic reg_write_t make_write(input logic en, input reg_id_t id,
			input word_t data);
		reg_write_t w;
		w.en = en;
		w.id = id;
		w.data = data;
		return w;
	endfunction

	// expected port output: $zero reads zero, a pending write to the same
	// register is forwarded, otherwise the stored word comes back
	function automatic word_t expected_read(input reg_array_t model, input reg_id_t id,
			input reg_write_t pending);
		if (id == 5'd0) begin
			return 32'd0;
		end
		if (pending.en && (pending.id == id)) begin
			return pending.data;
		end
		return model[id];
	endfunction

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s expected %h, got %h",
				$time, name, expected, actual);
			$display("Some tests failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// present one cycle of inputs and move to the drive point of the next cycle
	task automatic apply_cycle(input reg_write_t next_write, input reg_id_t id0,
			input reg_id_t id1);
		write = next_write;
		read_id[0] = id0;
		read_id[1] = id1;
		@(posedge clock);
		#DRIVE_DELAY;
	endtask

	// the model follows the storage rule at every rising edge
	always @(posedge clock) begin
		if (reset) begin
			shadow = '0;
			model_valid = 1'b1;
		end else if (write.en && (write.id != 5'd0)) begin
			shadow[write.id] = write.data;
		end
	end

	// compare both ports once the inputs of the cycle have settled
	always @(posedge clock) begin
		#CHECK_DELAY;
		if (model_valid) begin
			for (int p = 0; p < NUM_READ_PORTS; p++) begin
				check_value($sformatf("read_value[%0d]", p),
					expected_read(shadow, read_id[p], write), read_value[p]);
			end
		end
	end

	// a failed bound assertion ends the run just like a failed compare
	always @(negedge clock) begin
		if (dut.u_assertions.failures != 0) begin
			$display("ERROR: a bound assertion failed in the DUT");
			$display("Some tests failed");
			$fatal(1, "stopped after an assertion failure");
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			$display("TIMEOUT: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	initial begin
		reg_write_t w;
		reg_write_t idle;
		reg_id_t    id;
		reg_id_t    other;
		logic [1:0] pick;
		write = '0;
		read_id[0] = '0;
		read_id[1] = '0;
		reset_request = 1'b0;
		shadow = '0;
		model_valid = 1'b0;
		lfsr_state = LFSR_SEED;
		cycle_count = 0;
		idle = make_write(1'b0, 5'd0, 32'd0);
		wait (power_on_reset === 1'b0);
		@(posedge clock);
		#DRIVE_DELAY;

		// everything reads zero after reset, each port walks its own order
		for (int i = 0; i < REG_COUNT; i++) begin
			apply_cycle(idle, reg_id_t'(i), reg_id_t'(REG_COUNT - 1 - i));
		end

		// fill registers 1 to 31 and read each one back on both ports
		for (int i = 1; i < REG_COUNT; i++) begin
			apply_cycle(make_write(1'b1, reg_id_t'(i), fill_value(reg_id_t'(i))),
				reg_id_t'(i - 1), 5'd0);
		end
		for (int i = 1; i < REG_COUNT; i++) begin
			apply_cycle(idle, reg_id_t'(i), reg_id_t'(i));
		end

		// writes to $zero are dropped and are not forwarded
		apply_cycle(make_write(1'b1, 5'd0, '1), 5'd0, 5'd0);
		apply_cycle(make_write(1'b1, 5'd0, 32'h1234_5678), 5'd0, 5'd1);
		apply_cycle(idle, 5'd0, 5'd0);

		// with the enable low, id and data must leave every register alone
		for (int i = 0; i < 16; i++) begin
			id = reg_id_t'(random_bits(5));
			apply_cycle(make_write(1'b0, id, random_bits(32)), id, id ^ 5'h0f);
		end
		for (int i = 1; i < REG_COUNT; i++) begin
			apply_cycle(idle, reg_id_t'(i), reg_id_t'(REG_COUNT - i));
		end

		// same-cycle reads see the new data on one port or on both
		for (int i = 0; i < 8; i++) begin
			id = reg_id_t'(random_bits(5));
			if (id == 5'd0) begin
				id = 5'd1;
			end
			other = id ^ 5'h10;
			apply_cycle(make_write(1'b1, id, random_bits(32)), id, other);
			apply_cycle(make_write(1'b1, id, random_bits(32)), other, id);
			apply_cycle(make_write(1'b1, id, random_bits(32)), id, id);
		end

		// random traffic with a second reset in the middle
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			reset_request = (i == MID_RESET_AT) || (i == MID_RESET_AT + 1);
			w.en = 1'(random_bits(1));
			w.id = reg_id_t'(random_bits(5));
			w.data = random_bits(32);
			pick = 2'(random_bits(2));
			// reading the write target now and then keeps forwarding busy
			if (pick[0]) begin
				id = reg_id_t'(random_bits(5));
			end else begin
				id = w.id;
			end
			if (pick[1]) begin
				other = reg_id_t'(random_bits(5));
			end else begin
				other = w.id;
			end
			apply_cycle(w, id, other);
		end
		reset_request = 1'b0;
		apply_cycle(idle, 5'd0, 5'd0);

		// assertions of the last edge have not been seen by the watcher yet
		if (dut.u_assertions.failures != 0) begin
			$display("ERROR: %0d bound assertions failed during the run",
				dut.u_assertions.failures);
			$display("Some tests failed");
			$fatal(1, "assertion failures in the DUT");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule
